// ==== cgra_macros.svh ====
`ifndef CGRA_MACROS_SVH
`define CGRA_MACROS_SVH

`define CGRA_DATA_W     16
`define CGRA_THREADS    8
`define CGRA_THREAD_W   3
`define CGRA_PC_W       8
`define CGRA_RF_ADDR_W  4
`define CGRA_CONF_W     64

// instruction fields
`define CGRA_OP_MSB     15
`define CGRA_OP_LSB     12
`define CGRA_MUXB_BIT   11  // 0 selects registered inb, 1 the register file
`define CGRA_RFWE_BIT   10
`define CGRA_OUTA_BIT   9
`define CGRA_OUTB_BIT   8
`define CGRA_RADDR_MSB  7
`define CGRA_RADDR_LSB  4
`define CGRA_WADDR_MSB  3
`define CGRA_WADDR_LSB  0

`endif

// ==== cgra_pkg.sv ====
`include "cgra_macros.svh"

package cgra_pkg;

  typedef logic [`CGRA_DATA_W-1:0]    data_t;
  typedef logic [`CGRA_THREAD_W-1:0]  thread_t;
  typedef logic [`CGRA_PC_W-1:0]      pc_t;
  typedef logic [`CGRA_RF_ADDR_W-1:0] rf_addr_t;
  typedef logic [`CGRA_DATA_W-1:0]    inst_t;   // same width as a datum
  typedef logic [`CGRA_CONF_W-1:0]    conf_word_t;
  typedef logic [7:0]                 pe_id_t;

  typedef enum logic [3:0] {
    OP_NOP   = 4'd0,
    OP_ADD   = 4'd1,
    OP_SUB   = 4'd2,
    OP_MUL   = 4'd3,   // low half of the product
    OP_AND   = 4'd4,
    OP_OR    = 4'd5,
    OP_XOR   = 4'd6,
    OP_SHL   = 4'd7,
    OP_SHR   = 4'd8,   // shift amount is b[3:0]
    OP_PASSA = 4'd9,
    OP_PASSB = 4'd10,
    OP_BEQ   = 4'd11,
    OP_SEL   = 4'd12   // a when branch_in, else b
  } alu_op_e;

  // ##########################################################
  // configuration word layout
  //   [63:56] pe_id
  //   [55:52] kind
  //   [50:48] thread
  //   [47:40] address, instruction address or register in [43:40]
  //   [15:0]  data, pc words use only [7:0]
  // ##########################################################
  typedef enum logic [3:0] {
    CONF_IDLE    = 4'd0,
    CONF_INST    = 4'd1,
    CONF_CONST   = 4'd2,
    CONF_PC_MAX  = 4'd3,
    CONF_PC_LOOP = 4'd4
  } conf_kind_e;

endpackage

// ==== cgra_conf_reader.sv ====
`timescale 1ns/100ps

module cgra_conf_reader #(
  parameter cgra_pkg::pe_id_t PE_ID = 8'd0
) (
  input  logic                 clk,
  input  logic                 rst,
  input  cgra_pkg::conf_word_t conf_bus_in,
  output logic                 inst_we,
  output logic                 const_we,
  output logic                 pc_max_we,
  output logic                 pc_loop_we,
  output cgra_pkg::thread_t    conf_thread,
  output cgra_pkg::pc_t        conf_addr,
  output cgra_pkg::data_t      conf_data
);
  import cgra_pkg::*;

  pe_id_t     word_id;
  conf_kind_e kind;
  logic       hit;

  assign word_id = conf_bus_in[63:56];
  assign kind    = conf_kind_e'(conf_bus_in[55:52]);
  assign hit     = (kind != CONF_IDLE) && (word_id == PE_ID);

  // one strobe per accepted word, one cycle after it is seen
  always_ff @(posedge clk) begin
    if (rst) begin
      inst_we    <= 1'b0;
      const_we   <= 1'b0;
      pc_max_we  <= 1'b0;
      pc_loop_we <= 1'b0;
    end else begin
      inst_we    <= hit && (kind == CONF_INST);
      const_we   <= hit && (kind == CONF_CONST);
      pc_max_we  <= hit && (kind == CONF_PC_MAX);
      pc_loop_we <= hit && (kind == CONF_PC_LOOP);
    end
  end

  // fields only change when a word is ours
  always_ff @(posedge clk) begin
    if (hit) begin
      conf_thread <= conf_bus_in[50:48];
      conf_addr   <= conf_bus_in[47:40];
      conf_data   <= conf_bus_in[15:0];
    end
  end

endmodule

// ==== cgra_thread_sched.sv ====
`include "cgra_macros.svh"
`timescale 1ns/100ps

module cgra_thread_sched (
  input  logic              clk,
  input  logic              rst,
  input  logic              en,
  input  logic              pc_max_we,
  input  logic              pc_loop_we,
  input  cgra_pkg::thread_t conf_thread,
  input  cgra_pkg::data_t   conf_data,
  output cgra_pkg::thread_t thread_idx,
  output cgra_pkg::pc_t     pc
);
  import cgra_pkg::*;

  pc_t pc_q    [`CGRA_THREADS];
  pc_t pc_max  [`CGRA_THREADS];
  pc_t pc_loop [`CGRA_THREADS];
  pc_t conf_pc;

  assign conf_pc = conf_data[`CGRA_PC_W-1:0];  // pc words use the low byte
  assign pc      = pc_q[thread_idx];

  // round robin, wraps with the counter width
  always_ff @(posedge clk) begin
    if (rst) thread_idx <= '0;
    else if (en) thread_idx <= thread_idx + 1'b1;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `CGRA_THREADS; i++) begin
        pc_max[i]  <= '0;
        pc_loop[i] <= '0;
      end
    end else begin
      if (pc_max_we) pc_max[conf_thread] <= conf_pc;
      if (pc_loop_we) pc_loop[conf_thread] <= conf_pc;
    end
  end

  // only the issuing thread moves
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `CGRA_THREADS; i++) pc_q[i] <= '0;
    end else if (en) begin
      if (pc == pc_max[thread_idx]) pc_q[thread_idx] <= pc_loop[thread_idx];
      else pc_q[thread_idx] <= pc + 1'b1;
    end
  end

endmodule

// ==== cgra_inst_decode.sv ====
`include "cgra_macros.svh"
`timescale 1ns/100ps

module cgra_inst_decode (
  input  cgra_pkg::inst_t    inst,
  output cgra_pkg::alu_op_e  op,
  output logic               mux_b,
  output logic               rf_we,
  output logic               out_a_en,
  output logic               out_b_en,
  output cgra_pkg::rf_addr_t rf_raddr,
  output cgra_pkg::rf_addr_t rf_waddr
);
  import cgra_pkg::*;

  logic live;  // anything but a nop

  assign op   = alu_op_e'(inst[`CGRA_OP_MSB:`CGRA_OP_LSB]);
  assign live = (op != OP_NOP);

  assign mux_b    = inst[`CGRA_MUXB_BIT];
  assign rf_we    = live && inst[`CGRA_RFWE_BIT];
  assign out_a_en = live && inst[`CGRA_OUTA_BIT];
  assign out_b_en = live && inst[`CGRA_OUTB_BIT];

  assign rf_raddr = inst[`CGRA_RADDR_MSB:`CGRA_RADDR_LSB];
  assign rf_waddr = inst[`CGRA_WADDR_MSB:`CGRA_WADDR_LSB];

endmodule

// ==== cgra_alu.sv ====
`timescale 1ns/100ps

module cgra_alu (
  input  cgra_pkg::alu_op_e op,
  input  cgra_pkg::data_t   a,
  input  cgra_pkg::data_t   b,
  input  logic              branch_in,
  output cgra_pkg::data_t   result,
  output logic              cmp
);
  import cgra_pkg::*;

  data_t product;

  assign cmp     = (a == b);
  assign product = a * b;  // keeps the low half

  always_comb begin
    case (op)
      OP_ADD:   result = a + b;
      OP_SUB:   result = a - b;
      OP_MUL:   result = product;
      OP_AND:   result = a & b;
      OP_OR:    result = a | b;
      OP_XOR:   result = a ^ b;
      OP_SHL:   result = a << b[3:0];
      OP_SHR:   result = a >> b[3:0];
      OP_PASSA: result = a;
      OP_PASSB: result = b;
      OP_BEQ:   result = data_t'(cmp);  // flag also visible on the data path
      OP_SEL:   result = branch_in ? a : b;
      default:  result = '0;
    endcase
  end

endmodule

// ==== cgra_pe.sv ====
`include "cgra_macros.svh"
`timescale 1ns/100ps

module cgra_pe #(
  parameter cgra_pkg::pe_id_t PE_ID = 8'd0
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 en,
  input  cgra_pkg::conf_word_t conf_bus_in,
  input  cgra_pkg::data_t      ina,
  input  cgra_pkg::data_t      inb,
  input  logic                 branch_in,
  output cgra_pkg::data_t      outa,
  output cgra_pkg::data_t      outb,
  output logic                 branch_out
);
  import cgra_pkg::*;

  localparam int IMEM_DEPTH = 1 << (`CGRA_THREAD_W + `CGRA_PC_W);
  localparam int RF_DEPTH   = 1 << (`CGRA_THREAD_W + `CGRA_RF_ADDR_W);

  logic     inst_we, const_we, pc_max_we, pc_loop_we;
  thread_t  conf_thread;
  pc_t      conf_addr;
  data_t    conf_data;

  thread_t  thread_idx, thread_p, thread_pp;
  pc_t      pc;

  inst_t    imem [IMEM_DEPTH];
  data_t    rf   [RF_DEPTH];
  inst_t    inst_q;
  inst_t    issue_inst;
  logic     bubble;

  alu_op_e  dec_op, op_q;
  logic     dec_mux_b, dec_rf_we, dec_out_a_en, dec_out_b_en;
  logic     mux_b_q, rf_we_q, out_a_en_q, out_b_en_q;
  rf_addr_t dec_raddr, dec_waddr, rf_waddr_q;
  data_t    ina_q, inb_q, rf_rdata, alu_b, result;
  logic     branch_in_q, cmp;

  cgra_conf_reader #(.PE_ID(PE_ID)) conf_reader (
    .clk(clk),
    .rst(rst),
    .conf_bus_in(conf_bus_in),
    .inst_we(inst_we),
    .const_we(const_we),
    .pc_max_we(pc_max_we),
    .pc_loop_we(pc_loop_we),
    .conf_thread(conf_thread),
    .conf_addr(conf_addr),
    .conf_data(conf_data)
  );

  cgra_thread_sched sched (
    .clk(clk),
    .rst(rst),
    .en(en),
    .pc_max_we(pc_max_we),
    .pc_loop_we(pc_loop_we),
    .conf_thread(conf_thread),
    .conf_data(conf_data),
    .thread_idx(thread_idx),
    .pc(pc)
  );

  // ##########################################################
  // fetch
  // ##########################################################
  always_ff @(posedge clk) begin
    if (inst_we) imem[{conf_thread, conf_addr}] <= conf_data;
  end

  always_ff @(posedge clk) begin
    if (en) inst_q <= imem[{thread_idx, pc}];
  end

  // set while en was low, so the held fetch is dropped on the rise
  always_ff @(posedge clk) begin
    if (rst) bubble <= 1'b1;
    else bubble <= ~en;
  end

  assign issue_inst = bubble ? '0 : inst_q;

  cgra_inst_decode decode (
    .inst(issue_inst),
    .op(dec_op),
    .mux_b(dec_mux_b),
    .rf_we(dec_rf_we),
    .out_a_en(dec_out_a_en),
    .out_b_en(dec_out_b_en),
    .rf_raddr(dec_raddr),
    .rf_waddr(dec_waddr)
  );

  // ##########################################################
  // operand stage
  // ##########################################################
  always_ff @(posedge clk) begin
    if (rst) begin
      thread_p   <= '0;
      thread_pp  <= '0;
      op_q       <= OP_NOP;
      mux_b_q    <= 1'b0;
      rf_we_q    <= 1'b0;
      out_a_en_q <= 1'b0;
      out_b_en_q <= 1'b0;
    end else if (en) begin
      thread_p   <= thread_idx;
      thread_pp  <= thread_p;
      op_q       <= dec_op;
      mux_b_q    <= dec_mux_b;
      rf_we_q    <= dec_rf_we;
      out_a_en_q <= dec_out_a_en;
      out_b_en_q <= dec_out_b_en;
    end
  end

  always_ff @(posedge clk) begin
    if (en) begin
      ina_q       <= ina;
      inb_q       <= inb;
      branch_in_q <= branch_in;
      rf_waddr_q  <= dec_waddr;
      rf_rdata    <= rf[{thread_p, dec_raddr}];
    end
  end

  // constant loads win over writeback
  always_ff @(posedge clk) begin
    if (const_we) rf[{conf_thread, conf_addr[`CGRA_RF_ADDR_W-1:0]}] <= conf_data;
    else if (en && rf_we_q) rf[{thread_pp, rf_waddr_q}] <= result;
  end

  // ##########################################################
  // execute and outputs
  // ##########################################################
  assign alu_b = mux_b_q ? rf_rdata : inb_q;

  cgra_alu alu (
    .op(op_q),
    .a(ina_q),
    .b(alu_b),
    .branch_in(branch_in_q),
    .result(result),
    .cmp(cmp)
  );

  always_ff @(posedge clk) begin
    if (rst) begin
      outa       <= '0;
      outb       <= '0;
      branch_out <= 1'b0;
    end else if (en) begin
      if (out_a_en_q) outa <= result;
      if (out_b_en_q) outb <= result;
      if (op_q == OP_BEQ) branch_out <= cmp;  // held by every other op
    end
  end

endmodule

// ==== cgra_array.sv ====
`timescale 1ns/100ps

module cgra_array (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 en,
  input  cgra_pkg::conf_word_t conf_bus_in,
  input  cgra_pkg::data_t      ina,
  input  cgra_pkg::data_t      inb,
  input  logic                 branch_in,
  output cgra_pkg::data_t      outb0,
  output cgra_pkg::data_t      outa,
  output cgra_pkg::data_t      outb,
  output logic                 branch_out
);
  import cgra_pkg::*;

  data_t pe0_outa;
  logic  pe0_branch;

  // head of the chain
  cgra_pe #(.PE_ID(8'd0)) pe0 (
    .clk(clk),
    .rst(rst),
    .en(en),
    .conf_bus_in(conf_bus_in),
    .ina(ina),
    .inb(inb),
    .branch_in(branch_in),
    .outa(pe0_outa),
    .outb(outb0),
    .branch_out(pe0_branch)
  );

  cgra_pe #(.PE_ID(8'd1)) pe1 (
    .clk(clk),
    .rst(rst),
    .en(en),
    .conf_bus_in(conf_bus_in),
    .ina(pe0_outa),
    .inb(inb),             // shares the array inb with pe0
    .branch_in(pe0_branch),
    .outa(outa),
    .outb(outb),
    .branch_out(branch_out)
  );

endmodule

// ==== cgra_sva.sv ====
`timescale 1ns/100ps

module cgra_sva (
  input logic            clk,
  input logic            rst,
  input logic            en,
  input logic            inst_we,
  input logic            const_we,
  input logic            pc_max_we,
  input logic            pc_loop_we,
  input cgra_pkg::data_t outa
);

  // ##########################################################
  // configuration strobes
  // ##########################################################
  one_strobe: assert property (@(posedge clk) disable iff (rst)
    $onehot0({inst_we, const_we, pc_max_we, pc_loop_we}))
    else $error("more than one configuration strobe high");

  quiet_after_reset: assert property (@(posedge clk) $fell(rst) |-> !const_we)
    else $error("const_we high in the first cycle after reset");

  // pipeline frozen while disabled
  outa_hold: assert property (@(posedge clk) (!en && !rst) |=> $stable(outa))
    else $error("outa changed while en was low");

endmodule

// ==== cgra_tb.sv ====
`include "cgra_macros.svh"
`timescale 1ns/100ps

module cgra_tb;
  import cgra_pkg::*;

  localparam int RUN_CYCLES     = 900;
  localparam int TIMEOUT_CYCLES = 3000;

  logic       clk;
  logic       rst;
  logic       en;
  conf_word_t conf_bus_in;
  data_t      ina, inb;
  logic       branch_in;
  data_t      outb0, outa, outb;
  logic       branch_out;

  integer seed     = 32'h9ea220cc;
  int     cycles   = 0;
  logic   checking = 1'b0;

  // ##########################################################
  // reference state where index 0 is pe0 and 1 is pe1
  // ##########################################################
  data_t      m_imem [2][1 << (`CGRA_THREAD_W + `CGRA_PC_W)];
  data_t      m_rf [2][1 << (`CGRA_THREAD_W + `CGRA_RF_ADDR_W)];
  pc_t        m_pc [2][`CGRA_THREADS];
  pc_t        m_pcmax [2][`CGRA_THREADS];
  pc_t        m_pcloop [2][`CGRA_THREADS];
  thread_t    m_thr [2], m_thr_p [2], m_thr_pp [2];
  inst_t      m_inst [2];
  logic [3:0] m_op [2];
  logic       m_bubble [2], m_muxb [2], m_rfwe [2], m_oae [2], m_obe [2];
  rf_addr_t   m_waddr [2];
  data_t      m_a [2], m_b [2], m_rd [2];
  logic       m_bin [2];
  data_t      m_outa [2], m_outb [2];
  logic       m_br [2];
  logic       m_pend [2];   // accepted word whose write lands on the next edge
  conf_word_t m_pword [2];

  cgra_array uut (.*);

  bind cgra_pe cgra_sva sva (
    .clk(clk),
    .rst(rst),
    .en(en),
    .inst_we(inst_we),
    .const_we(const_we),
    .pc_max_we(pc_max_we),
    .pc_loop_we(pc_loop_we),
    .outa(outa)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles == TIMEOUT_CYCLES) begin
      $display("timeout after %0d cycles, the run never reached its end", cycles);
      $display("STATUS: FAIL");
      $fatal(1, "timeout");
    end
  end

  function automatic logic [31:0] rand32();
    return $random(seed);
  endfunction

  function automatic conf_word_t conf_word(input pe_id_t id, input logic [3:0] kind,
                                           input thread_t thr, input pc_t addr,
                                           input data_t data);
    return {id, kind, 1'b0, thr, addr, 24'd0, data};
  endfunction

  function automatic inst_t rand_inst();
    logic [31:0] r;
    logic [15:0] op;
    r  = rand32();
    op = r[31:16] % 16'd13;  // legal opcodes only
    return {op[3:0], r[11:0]};
  endfunction

  function automatic data_t alu_model(input logic [3:0] op, input data_t a, input data_t b,
                                      input logic sel);
    logic [31:0] prod;
    prod = a * b;
    case (op)
      OP_ADD:   return a + b;
      OP_SUB:   return a - b;
      OP_MUL:   return prod[15:0];
      OP_AND:   return a & b;
      OP_OR:    return a | b;
      OP_XOR:   return a ^ b;
      OP_SHL:   return a << b[3:0];
      OP_SHR:   return a >> b[3:0];
      OP_PASSA: return a;
      OP_PASSB: return b;
      OP_BEQ:   return {15'd0, a == b};
      OP_SEL:   return sel ? a : b;
      default:  return 16'd0;
    endcase
  endfunction

  task automatic check_value(input string name, input data_t got, input data_t exp);
    if (got !== exp) begin
      $display("Mismatch at %0d ns: %s is %h, expected %h", $time, name, got, exp);
      $display("STATUS: FAIL");
      $fatal(1, "output mismatch");
    end
  endtask

  // one clock edge of one element
  task automatic model_edge(input logic p, input data_t a_in, input logic br_in);
    data_t      bval, res, rd_new, fetched;
    inst_t      issue;
    thread_t    t;
    pc_t        pcv;
    logic       live, const_now;
    conf_word_t w;
    if (rst) begin
      m_pend[p]   = 1'b0;
      m_thr[p]    = '0;
      m_thr_p[p]  = '0;
      m_thr_pp[p] = '0;
      m_op[p]     = '0;
      m_muxb[p]   = 1'b0;
      m_rfwe[p]   = 1'b0;
      m_oae[p]    = 1'b0;
      m_obe[p]    = 1'b0;
      m_outa[p]   = '0;
      m_outb[p]   = '0;
      m_br[p]     = 1'b0;
      m_bubble[p] = 1'b1;
      for (int i = 0; i < `CGRA_THREADS; i++) begin
        m_pc[p][i[2:0]]     = '0;
        m_pcmax[p][i[2:0]]  = '0;
        m_pcloop[p][i[2:0]] = '0;
      end
    end else begin
      w         = m_pword[p];
      const_now = m_pend[p] && (w[55:52] == CONF_CONST);
      bval      = m_muxb[p] ? m_rd[p] : m_b[p];
      res       = alu_model(m_op[p], m_a[p], bval, m_bin[p]);
      t         = m_thr[p];
      pcv       = m_pc[p][t];
      fetched   = m_imem[p][{t, pcv}];
      issue     = m_bubble[p] ? '0 : m_inst[p];
      live      = (issue[15:12] != 4'd0);
      rd_new    = m_rf[p][{m_thr_p[p], issue[7:4]}];
      if (en) begin
        if (m_oae[p]) m_outa[p] = res;
        if (m_obe[p]) m_outb[p] = res;
        if (m_op[p] == OP_BEQ) m_br[p] = (m_a[p] == bval);
        if (m_rfwe[p] && !const_now) m_rf[p][{m_thr_pp[p], m_waddr[p]}] = res;
        m_op[p]     = issue[15:12];
        m_muxb[p]   = issue[11];
        m_rfwe[p]   = live && issue[10];
        m_oae[p]    = live && issue[9];
        m_obe[p]    = live && issue[8];
        m_waddr[p]  = issue[3:0];
        m_a[p]      = a_in;
        m_b[p]      = inb;
        m_bin[p]    = br_in;
        m_rd[p]     = rd_new;
        m_thr_pp[p] = m_thr_p[p];
        m_thr_p[p]  = t;
        m_inst[p]   = fetched;
        m_pc[p][t]  = (pcv == m_pcmax[p][t]) ? m_pcloop[p][t] : pcv + 8'd1;
        m_thr[p]    = t + 3'd1;
      end
      m_bubble[p] = !en;
      if (m_pend[p]) begin
        case (w[55:52])
          CONF_INST:    m_imem[p][{w[50:48], w[47:40]}] = w[15:0];
          CONF_CONST:   m_rf[p][{w[50:48], w[43:40]}] = w[15:0];
          CONF_PC_MAX:  m_pcmax[p][w[50:48]] = w[7:0];
          CONF_PC_LOOP: m_pcloop[p][w[50:48]] = w[7:0];
          default: ;
        endcase
      end
      m_pend[p] = (conf_bus_in[55:52] != CONF_IDLE) && (conf_bus_in[63:56] == {7'd0, p});
    end
    m_pword[p] = conf_bus_in;
  endtask

  task automatic next_cycle();
    @(posedge clk);
    model_edge(1'b1, m_outa[0], m_br[0]);  // pe1 takes pe0 values from before the edge
    model_edge(1'b0, ina, branch_in);
  endtask

  // idle and foreign words get mixed in ahead of the real one
  task automatic send_conf(input conf_word_t word);
    logic [31:0] r;
    r = rand32();
    if (r[1:0] == 2'd0) begin
      conf_bus_in <= {r[31:24], 56'd0};
      next_cycle();
    end
    if (r[4:2] == 3'd0) begin
      conf_bus_in <= conf_word(8'd5, {2'b00, r[6:5]} + 4'd1, r[10:8], r[23:16], r[31:16]);
      next_cycle();
    end
    conf_bus_in <= word;
    next_cycle();
  endtask

  always @(negedge clk) begin
    if (checking) begin
      check_value("outb0", outb0, m_outb[0]);
      check_value("outa", outa, m_outa[1]);
      check_value("outb", outb, m_outb[1]);
      check_value("branch_out", {15'd0, branch_out}, {15'd0, m_br[1]});
    end
  end

  initial begin
    logic [31:0] r;
    pc_t         pmax, ploop;
    rst         = 1'b1;
    en          = 1'b0;
    conf_bus_in = '0;
    ina         = '0;
    inb         = '0;
    branch_in   = 1'b0;
    repeat (5) next_cycle();
    rst <= 1'b0;
    checking = 1'b1;

    // ##########################################################
    // load both elements with en low
    // ##########################################################
    for (int pi = 0; pi < 2; pi++) begin
      for (int t = 0; t < `CGRA_THREADS; t++) begin
        for (int a = 0; a < 8; a++)
          send_conf(conf_word({7'd0, pi[0]}, CONF_INST, t[2:0], a[7:0], rand_inst()));
        for (int a = 0; a < 16; a++) begin
          r = rand32();
          send_conf(conf_word({7'd0, pi[0]}, CONF_CONST, t[2:0], a[7:0], r[15:0]));
        end
        r = rand32();
        pmax = {5'd0, r[2:0]};
        if (pi == 0 && t == 0) pmax = 8'd0;  // single instruction loop
        if (pi == 0 && t == 1) pmax = 8'd6;
        ploop = {5'd0, r[10:8]} % (pmax + 8'd1);
        if (pi == 0 && t == 1) ploop = 8'd3;
        send_conf(conf_word({7'd0, pi[0]}, CONF_PC_MAX, t[2:0], 8'd0, {8'd0, pmax}));
        send_conf(conf_word({7'd0, pi[0]}, CONF_PC_LOOP, t[2:0], 8'd0, {8'd0, ploop}));
      end
    end
    conf_bus_in <= '0;
    repeat (2) next_cycle();

    // ##########################################################
    // run with en steady at first and then toggling
    // ##########################################################
    for (int c = 0; c < RUN_CYCLES; c++) begin
      r = rand32();
      ina <= r[15:0];
      if (r[18:16] == 3'd0) inb <= r[15:0];  // equal operands so beq can hit
      else inb <= r[31:16];
      branch_in <= r[19];
      if (c < 400) en <= 1'b1;
      else en <= (r[21:20] != 2'd0);
      next_cycle();
    end
    en <= 1'b0;
    repeat (3) next_cycle();

    $display("STATUS: PASS");
    $finish;
  end

endmodule

// ==== cgra.f ====
+incdir+.
cgra_pkg.sv
cgra_conf_reader.sv
cgra_thread_sched.sv
cgra_inst_decode.sv
cgra_alu.sv
cgra_pe.sv
cgra_array.sv
cgra_sva.sv
cgra_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the cgra testbench with verilator

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
  echo "cannot enter the project directory"
  exit 1
fi

verilator --binary --timing --assert --top-module cgra_tb -f cgra.f -o cgra_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/cgra_sim > sim.log 2>&1
run_status=$?
cat sim.log

if grep -q "STATUS: FAIL" sim.log; then
  exit 1
fi
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi
exit 0
